// ==== rtl/riscv_macros.svh ====
`ifndef RISCV_MACROS_SVH
`define RISCV_MACROS_SVH

// machine word and register file geometry
`define RISCV_XLEN      32
`define RISCV_NREGS     32

`define RISCV_RESET_PC  32'h0000_0000

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// major opcodes, inst[6:0]
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define RISCV_OP_LUI    7'b0110111
`define RISCV_OP_JAL    7'b1101111
`define RISCV_OP_BRANCH 7'b1100011
`define RISCV_OP_LOAD   7'b0000011
`define RISCV_OP_STORE  7'b0100011
`define RISCV_OP_IMM    7'b0010011
`define RISCV_OP_REG    7'b0110011

`endif

// ==== rtl/riscv_pkg.sv ====
`default_nettype none

`include "riscv_macros.svh"

package riscv_pkg;

  typedef logic [`RISCV_XLEN-1:0] word_t;
  typedef logic [$clog2(`RISCV_NREGS)-1:0] reg_idx_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS
  } alu_op_e;

  // what the execute unit does with the instruction
  typedef enum logic [2:0] {
    CLS_ALU,
    CLS_BEQ,
    CLS_BNE,
    CLS_JAL,
    CLS_LOAD,
    CLS_STORE,
    CLS_NOP
  } inst_class_e;

  typedef struct packed {
    inst_class_e iclass;
    alu_op_e     alu_op;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    word_t       imm;
    logic        use_imm;
    word_t       pc;
  } dec_t;

endpackage

`default_nettype wire

// ==== rtl/riscv_ifu.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "riscv_macros.svh"

module riscv_ifu import riscv_pkg::*; (
  input  logic  clk,
  input  logic  i_rst_n,

  input  logic  i_retire,
  input  word_t i_next_pc,

  input  logic  i_instbus_ack,
  input  word_t i_instbus_data,
  output logic  o_instbus_req,
  output word_t o_instbus_addr,

  output logic  o_ifu_vld,
  output word_t o_ifu_inst,
  output word_t o_ifu_pc
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FETCH,
    ST_WAIT
  } state_e;

  state_e state;
  word_t  pc;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // fetch sequencing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= ST_IDLE;
      pc    <= `RISCV_RESET_PC;
    end else begin
      case (state)
        ST_IDLE: state <= ST_FETCH;
        ST_FETCH: begin
          if (i_instbus_ack) begin
            state <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          // one instruction in flight, so refetch only after retire
          if (i_retire) begin
            pc    <= i_next_pc;
            state <= ST_FETCH;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign o_instbus_req  = (state == ST_FETCH);
  assign o_instbus_addr = pc;

  // instruction handed on in the ack cycle
  assign o_ifu_vld  = o_instbus_req & i_instbus_ack;
  assign o_ifu_inst = i_instbus_data;
  assign o_ifu_pc   = pc;

  // retire only for the instruction already fetched
  a_retire_waiting: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_retire |-> state == ST_WAIT);

endmodule

`default_nettype wire

// ==== rtl/riscv_idu.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "riscv_macros.svh"

module riscv_idu import riscv_pkg::*; (
  input  logic  clk,
  input  logic  i_rst_n,

  input  logic  i_ifu_vld,
  input  word_t i_ifu_inst,
  input  word_t i_ifu_pc,

  output logic  o_idu_vld,
  output dec_t  o_dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;
  dec_t       dec_nxt;

  assign opcode = i_ifu_inst[6:0];
  assign funct3 = i_ifu_inst[14:12];
  assign funct7 = i_ifu_inst[31:25];

  // immediate formats
  assign imm_i = {{20{i_ifu_inst[31]}}, i_ifu_inst[31:20]};
  assign imm_s = {{20{i_ifu_inst[31]}}, i_ifu_inst[31:25], i_ifu_inst[11:7]};
  assign imm_b = {{19{i_ifu_inst[31]}}, i_ifu_inst[31], i_ifu_inst[7],
                  i_ifu_inst[30:25], i_ifu_inst[11:8], 1'b0};
  assign imm_j = {{11{i_ifu_inst[31]}}, i_ifu_inst[31], i_ifu_inst[19:12],
                  i_ifu_inst[20], i_ifu_inst[30:21], 1'b0};
  assign imm_u = {i_ifu_inst[31:12], 12'b0};

  always_comb begin
    dec_nxt         = '0;
    dec_nxt.iclass  = CLS_NOP;
    dec_nxt.alu_op  = ALU_ADD;
    dec_nxt.rd      = i_ifu_inst[11:7];
    dec_nxt.rs1     = i_ifu_inst[19:15];
    dec_nxt.rs2     = i_ifu_inst[24:20];
    dec_nxt.imm     = imm_i;
    dec_nxt.use_imm = 1'b1;
    dec_nxt.pc      = i_ifu_pc;
    case (opcode)
      `RISCV_OP_LUI: begin
        dec_nxt.iclass = CLS_ALU;
        dec_nxt.alu_op = ALU_PASS;
        dec_nxt.imm    = imm_u;
      end
      `RISCV_OP_IMM: begin
        dec_nxt.iclass = CLS_ALU;
        case (funct3)
          3'b000: dec_nxt.alu_op = ALU_ADD;
          3'b100: dec_nxt.alu_op = ALU_XOR;
          3'b110: dec_nxt.alu_op = ALU_OR;
          3'b111: dec_nxt.alu_op = ALU_AND;
          default: dec_nxt.iclass = CLS_NOP;
        endcase
      end
      `RISCV_OP_REG: begin
        dec_nxt.iclass  = CLS_ALU;
        dec_nxt.use_imm = 1'b0;
        case ({funct7, funct3})
          10'b0000000_000: dec_nxt.alu_op = ALU_ADD;
          10'b0100000_000: dec_nxt.alu_op = ALU_SUB;
          10'b0000000_010: dec_nxt.alu_op = ALU_SLT;
          10'b0000000_100: dec_nxt.alu_op = ALU_XOR;
          10'b0000000_110: dec_nxt.alu_op = ALU_OR;
          10'b0000000_111: dec_nxt.alu_op = ALU_AND;
          default: dec_nxt.iclass = CLS_NOP;
        endcase
      end
      `RISCV_OP_BRANCH: begin
        dec_nxt.imm = imm_b;
        if (funct3 == 3'b000) begin
          dec_nxt.iclass = CLS_BEQ;
        end else if (funct3 == 3'b001) begin
          dec_nxt.iclass = CLS_BNE;
        end
      end
      `RISCV_OP_JAL: begin
        dec_nxt.iclass = CLS_JAL;
        dec_nxt.imm    = imm_j;
      end
      // word access only
      `RISCV_OP_LOAD: begin
        if (funct3 == 3'b010) dec_nxt.iclass = CLS_LOAD;
      end
      `RISCV_OP_STORE: begin
        dec_nxt.imm = imm_s;
        if (funct3 == 3'b010) dec_nxt.iclass = CLS_STORE;
      end
      default: dec_nxt.iclass = CLS_NOP;
    endcase
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_idu_vld <= 1'b0;
    end else begin
      o_idu_vld <= i_ifu_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (i_ifu_vld) begin
      o_dec <= dec_nxt;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/riscv_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "riscv_macros.svh"

module riscv_regfile import riscv_pkg::*; (
  input  logic     clk,
  input  logic     i_rst_n,

  input  reg_idx_t i_rs1,
  input  reg_idx_t i_rs2,
  output word_t    o_rs1_data,
  output word_t    o_rs2_data,

  input  logic     i_wr,
  input  reg_idx_t i_rd,
  input  word_t    i_rd_data
);

  // x1..x31, x0 has no storage
  word_t regs [1:`RISCV_NREGS-1];

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 1; i < `RISCV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wr && (i_rd != '0)) begin
      regs[i_rd] <= i_rd_data;
    end
  end

  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

`default_nettype wire

// ==== rtl/riscv_exu.sv ====
`timescale 1ns/1ns
`default_nettype none

module riscv_exu import riscv_pkg::*; (
  input  logic     clk,
  input  logic     i_rst_n,

  input  logic     i_idu_vld,
  input  dec_t     i_dec,

  output reg_idx_t o_rs1,
  output reg_idx_t o_rs2,
  input  word_t    i_rs1_data,
  input  word_t    i_rs2_data,
  output logic     o_rd_wr,
  output reg_idx_t o_rd,
  output word_t    o_rd_data,

  output logic     o_mem_start,
  output logic     o_mem_write,
  output word_t    o_mem_addr,
  output word_t    o_mem_wdata,
  input  logic     i_mem_done,
  input  word_t    i_mem_rdata,

  output logic     o_retire,
  output word_t    o_next_pc
);

  word_t    op_b;
  word_t    alu_res;
  word_t    pc_plus4;
  logic     is_mem;
  logic     taken;
  logic     mem_busy;
  logic     mem_is_ld;
  reg_idx_t ld_rd;

  assign o_rs1 = i_dec.rs1;
  assign o_rs2 = i_dec.rs2;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // alu and branch
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign op_b = i_dec.use_imm ? i_dec.imm : i_rs2_data;

  always_comb begin
    case (i_dec.alu_op)
      ALU_ADD:  alu_res = i_rs1_data + op_b;
      ALU_SUB:  alu_res = i_rs1_data - op_b;
      ALU_AND:  alu_res = i_rs1_data & op_b;
      ALU_OR:   alu_res = i_rs1_data | op_b;
      ALU_XOR:  alu_res = i_rs1_data ^ op_b;
      ALU_SLT:  alu_res = {{($bits(word_t)-1){1'b0}}, $signed(i_rs1_data) < $signed(op_b)};
      default:  alu_res = op_b;
    endcase
  end

  assign taken = ((i_dec.iclass == CLS_BEQ) && (i_rs1_data == i_rs2_data)) ||
                 ((i_dec.iclass == CLS_BNE) && (i_rs1_data != i_rs2_data));

  assign pc_plus4  = i_dec.pc + 32'd4;
  assign o_next_pc = (taken || (i_dec.iclass == CLS_JAL)) ? i_dec.pc + i_dec.imm : pc_plus4;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // memory access and retire
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign is_mem      = (i_dec.iclass == CLS_LOAD) || (i_dec.iclass == CLS_STORE);
  assign o_mem_start = i_idu_vld & is_mem;
  assign o_mem_write = (i_dec.iclass == CLS_STORE);
  assign o_mem_addr  = i_rs1_data + i_dec.imm;
  assign o_mem_wdata = i_rs2_data;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      mem_busy  <= 1'b0;
      mem_is_ld <= 1'b0;
    end else if (o_mem_start) begin
      mem_busy  <= 1'b1;
      mem_is_ld <= (i_dec.iclass == CLS_LOAD);
    end else if (i_mem_done) begin
      mem_busy  <= 1'b0;
      mem_is_ld <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (o_mem_start) begin
      ld_rd <= i_dec.rd;
    end
  end

  assign o_retire = (i_idu_vld & ~is_mem) | i_mem_done;

  // load data lands when the bus acks, otherwise alu or link value
  assign o_rd_wr   = (i_idu_vld & ((i_dec.iclass == CLS_ALU) || (i_dec.iclass == CLS_JAL))) |
                     (i_mem_done & mem_is_ld);
  assign o_rd      = i_mem_done ? ld_rd : i_dec.rd;
  assign o_rd_data = i_mem_done ? i_mem_rdata :
                     (i_dec.iclass == CLS_JAL) ? pc_plus4 : alu_res;

  a_no_issue_busy: assert property (@(posedge clk) disable iff (!i_rst_n)
    mem_busy |-> !i_idu_vld);

endmodule

`default_nettype wire

// ==== rtl/riscv_lsu.sv ====
`timescale 1ns/1ns
`default_nettype none

module riscv_lsu import riscv_pkg::*; (
  input  logic  clk,
  input  logic  i_rst_n,

  input  logic  i_mem_start,
  input  logic  i_mem_write,
  input  word_t i_mem_addr,
  input  word_t i_mem_wdata,
  output logic  o_mem_done,
  output word_t o_mem_rdata,

  output logic  o_membus_req,
  output logic  o_membus_write,
  output word_t o_membus_addr,
  output word_t o_membus_data,
  input  logic  i_membus_ack,
  input  word_t i_membus_data
);

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_membus_req   <= 1'b0;
      o_membus_write <= 1'b0;
    end else if (i_mem_start) begin
      o_membus_req   <= 1'b1;
      o_membus_write <= i_mem_write;
    end else if (o_membus_req && i_membus_ack) begin
      o_membus_req   <= 1'b0;
      o_membus_write <= 1'b0;
    end
  end

  // held for the whole request
  always_ff @(posedge clk) begin
    if (i_mem_start) begin
      o_membus_addr <= i_mem_addr;
      o_membus_data <= i_mem_wdata;
    end
  end

  assign o_mem_done  = o_membus_req & i_membus_ack;
  assign o_mem_rdata = i_membus_data;

  a_start_idle: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_mem_start |-> !o_membus_req);

endmodule

`default_nettype wire

// ==== rtl/riscv.sv ====
`timescale 1ns/1ns
`default_nettype none

module riscv import riscv_pkg::*; (
  input  logic  clk,
  input  logic  i_rst_n,

  input  logic  i_instbus_ack,
  input  word_t i_instbus_data,
  output logic  o_instbus_req,
  output word_t o_instbus_addr,

  input  logic  i_membus_ack,
  input  word_t i_membus_data,
  output logic  o_membus_req,
  output logic  o_membus_write,
  output word_t o_membus_addr,
  output word_t o_membus_data
);

  logic     retire;
  word_t    next_pc;
  logic     ifu_vld;
  word_t    ifu_inst;
  word_t    ifu_pc;
  logic     idu_vld;
  dec_t     dec;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    rs1_data;
  word_t    rs2_data;
  logic     rd_wr;
  reg_idx_t rd;
  word_t    rd_data;
  logic     mem_start;
  logic     mem_write;
  word_t    mem_addr;
  word_t    mem_wdata;
  logic     mem_done;
  word_t    mem_rdata;

  riscv_ifu ifu (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_retire       (retire),
    .i_next_pc      (next_pc),
    .i_instbus_ack  (i_instbus_ack),
    .i_instbus_data (i_instbus_data),
    .o_instbus_req  (o_instbus_req),
    .o_instbus_addr (o_instbus_addr),
    .o_ifu_vld      (ifu_vld),
    .o_ifu_inst     (ifu_inst),
    .o_ifu_pc       (ifu_pc)
  );

  riscv_idu idu (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_ifu_vld  (ifu_vld),
    .i_ifu_inst (ifu_inst),
    .i_ifu_pc   (ifu_pc),
    .o_idu_vld  (idu_vld),
    .o_dec      (dec)
  );

  riscv_regfile regfile (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_wr       (rd_wr),
    .i_rd       (rd),
    .i_rd_data  (rd_data)
  );

  riscv_exu exu (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_idu_vld   (idu_vld),
    .i_dec       (dec),
    .o_rs1       (rs1),
    .o_rs2       (rs2),
    .i_rs1_data  (rs1_data),
    .i_rs2_data  (rs2_data),
    .o_rd_wr     (rd_wr),
    .o_rd        (rd),
    .o_rd_data   (rd_data),
    .o_mem_start (mem_start),
    .o_mem_write (mem_write),
    .o_mem_addr  (mem_addr),
    .o_mem_wdata (mem_wdata),
    .i_mem_done  (mem_done),
    .i_mem_rdata (mem_rdata),
    .o_retire    (retire),
    .o_next_pc   (next_pc)
  );

  riscv_lsu lsu (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_mem_start    (mem_start),
    .i_mem_write    (mem_write),
    .i_mem_addr     (mem_addr),
    .i_mem_wdata    (mem_wdata),
    .o_mem_done     (mem_done),
    .o_mem_rdata    (mem_rdata),
    .o_membus_req   (o_membus_req),
    .o_membus_write (o_membus_write),
    .o_membus_addr  (o_membus_addr),
    .o_membus_data  (o_membus_data),
    .i_membus_ack   (i_membus_ack),
    .i_membus_data  (i_membus_data)
  );

endmodule

`default_nettype wire

// ==== bench/riscv_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "riscv_macros.svh"

module riscv_tb import riscv_pkg::*; ();

  // about 30 instructions at up to 12 cycles each, plus reset and margin
  localparam int    MAX_CYCLES = 800;
  localparam word_t MARKER     = 32'h0000_0080;
  localparam word_t JAL_PC     = 32'd88;
  localparam word_t HALT_PC    = 32'd112;
  localparam word_t OPND_A     = 32'h0000_0123;
  localparam word_t OPND_B     = 32'hFFFF_FFF0;

  logic  clk;
  logic  i_rst_n;
  logic  i_instbus_ack;
  word_t i_instbus_data;
  logic  o_instbus_req;
  word_t o_instbus_addr;
  logic  i_membus_ack;
  word_t i_membus_data;
  logic  o_membus_req;
  logic  o_membus_write;
  word_t o_membus_addr;
  word_t o_membus_data;

  word_t imem [0:63];
  word_t dmem [0:63];
  word_t exp_data [0:63];
  logic  exp_vld [0:63];
  logic  seen [0:63];
  word_t exp_pc [0:39];
  int    n_inst;
  int    n_pc;
  int    fetch_idx;
  int    cycles;
  int    iwait;
  int    mwait;
  logic  ibusy;
  logic  mbusy;
  word_t held_iaddr;
  word_t held_maddr;
  logic  held_mwrite;
  word_t held_mdata;
  logic  rst_q;
  int    checks [1:6];
  int    errs [1:6];
  string test_name [1:6];

  riscv UUT (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_instbus_ack  (i_instbus_ack),
    .i_instbus_data (i_instbus_data),
    .o_instbus_req  (o_instbus_req),
    .o_instbus_addr (o_instbus_addr),
    .i_membus_ack   (i_membus_ack),
    .i_membus_data  (i_membus_data),
    .o_membus_req   (o_membus_req),
    .o_membus_write (o_membus_write),
    .o_membus_addr  (o_membus_addr),
    .o_membus_data  (o_membus_data)
  );

  always #10 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // instruction encoders
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic word_t imm_word(input word_t imm, input int rs1, input logic [2:0] f3,
                                     input int rd, input logic [6:0] op);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
  endfunction

  function automatic word_t reg_word(input logic [6:0] f7, input int rs2, input int rs1,
                                     input logic [2:0] f3, input int rd);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `RISCV_OP_REG};
  endfunction

  function automatic word_t store_word(input word_t imm, input int rs2, input int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], `RISCV_OP_STORE};
  endfunction

  function automatic word_t branch_word(input word_t imm, input int rs2, input int rs1,
                                        input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], `RISCV_OP_BRANCH};
  endfunction

  function automatic word_t jal_word(input word_t imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], `RISCV_OP_JAL};
  endfunction

  function automatic word_t lui_word(input logic [19:0] imm, input int rd);
    return {imm, rd[4:0], `RISCV_OP_LUI};
  endfunction

  function automatic int test_of_addr(input word_t a);
    if (a >= 32'h40 && a <= 32'h58) return 2;
    if (a == 32'h5C) return 3;
    if (a == 32'h68) return 5;
    return 4;
  endfunction

  task automatic place(input word_t w);
    imem[n_inst] = w;
    n_inst++;
  endtask

  task automatic expect_pc(input word_t a);
    exp_pc[n_pc] = a;
    n_pc++;
  endtask

  task automatic expect_store(input word_t a, input word_t v);
    exp_data[a[7:2]] = v;
    exp_vld[a[7:2]]  = 1'b1;
  endtask

  task automatic load_program();
    word_t preset;
    for (int i = 0; i < 64; i++) begin
      // spare slots hold addi x0, x0, i
      imem[i]     = imm_word(word_t'(i), 0, 3'b000, 0, `RISCV_OP_IMM);
      dmem[i]     = (word_t'(i) * 32'h0101_0101) ^ 32'h5A00_C3E1;
      exp_data[i] = '0;
      exp_vld[i]  = 1'b0;
      seen[i]     = 1'b0;
    end
    preset = dmem[8];
    place(imm_word(OPND_A, 0, 3'b000, 1, `RISCV_OP_IMM));
    place(imm_word(OPND_B, 0, 3'b000, 2, `RISCV_OP_IMM));
    place(reg_word(7'h00, 2, 1, 3'b000, 3));
    place(reg_word(7'h20, 2, 1, 3'b000, 4));
    place(reg_word(7'h00, 2, 1, 3'b111, 5));
    place(reg_word(7'h00, 2, 1, 3'b110, 6));
    place(reg_word(7'h00, 2, 1, 3'b100, 7));
    // slt x8, x2, x1
    place(reg_word(7'h00, 1, 2, 3'b010, 8));
    place(lui_word(20'hABCDE, 9));
    for (int r = 3; r <= 9; r++) begin
      place(store_word(word_t'(32'h40 + 4 * (r - 3)), r, 0));
    end
    place(imm_word(32'h55, 0, 3'b000, 0, `RISCV_OP_IMM));
    place(store_word(32'h5C, 0, 0));
    place(branch_word(32'd8, 1, 1, 3'b000));
    place(store_word(MARKER, 1, 0));
    place(branch_word(32'd8, 1, 1, 3'b001));
    place(store_word(32'h60, 2, 0));
    place(jal_word(32'd8, 11));
    place(store_word(MARKER, 1, 0));
    place(store_word(32'h64, 11, 0));
    place(imm_word(32'h20, 0, 3'b010, 12, `RISCV_OP_LOAD));
    place(imm_word(32'd1, 12, 3'b000, 12, `RISCV_OP_IMM));
    place(store_word(32'h68, 12, 0));
    // halt, jal x0 to itself
    place(jal_word(32'd0, 0));

    expect_store(32'h40, OPND_A + OPND_B);
    expect_store(32'h44, OPND_A - OPND_B);
    expect_store(32'h48, OPND_A & OPND_B);
    expect_store(32'h4C, OPND_A | OPND_B);
    expect_store(32'h50, OPND_A ^ OPND_B);
    expect_store(32'h54, ($signed(OPND_B) < $signed(OPND_A)) ? 32'd1 : 32'd0);
    expect_store(32'h58, {20'hABCDE, 12'h000});
    expect_store(32'h5C, '0);
    expect_store(32'h60, OPND_B);
    expect_store(32'h64, JAL_PC + 32'd4);
    expect_store(32'h68, preset + 32'd1);

    for (int a = 0; a <= 72; a += 4) begin
      expect_pc(word_t'(a));
    end
    expect_pc(32'd80);
    expect_pc(32'd84);
    expect_pc(JAL_PC);
    expect_pc(32'd96);
    expect_pc(32'd100);
    expect_pc(32'd104);
    expect_pc(32'd108);
    expect_pc(HALT_PC);
    for (int i = n_pc; i < 40; i++) begin
      exp_pc[i] = HALT_PC;
    end
  endtask

  task automatic report_test(input int n);
    $display("test %0d (%s): %0d checks, %0d errors", n, test_name[n], checks[n], errs[n]);
  endtask

  task automatic check_all_stores();
    int t;
    for (int a = 0; a < 64; a++) begin
      if (exp_vld[a]) begin
        t = test_of_addr(word_t'(a * 4));
        checks[t]++;
        a_store_seen: assert (seen[a]) else begin
          errs[t]++;
          $display("no store ever reached address %h", word_t'(a * 4));
        end
      end
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus models, 0 to 3 cycles of ack delay
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(negedge clk) begin
    if (!i_rst_n || i_instbus_ack) begin
      i_instbus_ack = 1'b0;
      ibusy         = 1'b0;
    end else if (o_instbus_req) begin
      if (!ibusy) begin
        ibusy      = 1'b1;
        iwait      = $urandom_range(3, 0);
        held_iaddr = o_instbus_addr;
      end
      if (iwait == 0) begin
        i_instbus_ack  = 1'b1;
        i_instbus_data = imem[o_instbus_addr[7:2]];
      end else begin
        iwait--;
      end
    end
  end

  always @(negedge clk) begin
    if (!i_rst_n || i_membus_ack) begin
      i_membus_ack = 1'b0;
      mbusy        = 1'b0;
    end else if (o_membus_req) begin
      if (!mbusy) begin
        mbusy       = 1'b1;
        mwait       = $urandom_range(3, 0);
        held_maddr  = o_membus_addr;
        held_mwrite = o_membus_write;
        held_mdata  = o_membus_data;
      end
      if (mwait == 0) begin
        i_membus_ack = 1'b1;
        if (o_membus_write) begin
          dmem[o_membus_addr[7:2]] = o_membus_data;
          seen[o_membus_addr[7:2]] = 1'b1;
        end else begin
          i_membus_data = dmem[o_membus_addr[7:2]];
        end
      end else begin
        mwait--;
      end
    end
  end

  // check tally and fetch position
  always @(posedge clk) begin
    rst_q <= i_rst_n;
    if (!i_rst_n) checks[1]++;
    if (i_rst_n && !rst_q) checks[1]++;
    if (o_instbus_req && i_instbus_ack) begin
      checks[4]++;
      fetch_idx <= fetch_idx + 1;
    end
    if (o_membus_req && o_membus_write && i_membus_ack) begin
      checks[test_of_addr(o_membus_addr)]++;
      checks[4]++;
    end
    if (i_rst_n && o_instbus_req) checks[6]++;
    if (i_rst_n && o_membus_req) checks[6] += 3;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("timeout: the program did not reach its halt loop in %0d cycles", MAX_CYCLES);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  a_reset_quiet: assert property (@(posedge clk) !i_rst_n |-> !o_instbus_req && !o_membus_req)
    else begin
      errs[1]++;
      $display("[ERROR] o_instbus_req/o_membus_req in reset expected 0/0 got %h/%h",
               $sampled(o_instbus_req), $sampled(o_membus_req));
    end

  a_first_fetch: assert property (@(posedge clk)
    $rose(i_rst_n) |=> o_instbus_req && (o_instbus_addr == `RISCV_RESET_PC))
    else begin
      errs[1]++;
      $display("[ERROR] o_instbus_req/o_instbus_addr first fetch expected 1/%h got %h/%h",
               `RISCV_RESET_PC, $sampled(o_instbus_req), $sampled(o_instbus_addr));
    end

  a_pc_order: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_instbus_req && i_instbus_ack |-> o_instbus_addr == exp_pc[fetch_idx])
    else begin
      errs[4]++;
      $display("[ERROR] o_instbus_addr fetch %0d expected %h got %h", $sampled(fetch_idx),
               exp_pc[$sampled(fetch_idx)], $sampled(o_instbus_addr));
    end

  a_store_data: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_membus_req && o_membus_write && i_membus_ack |->
      exp_vld[o_membus_addr[7:2]] && (o_membus_data == exp_data[o_membus_addr[7:2]]))
    else begin
      errs[test_of_addr($sampled(o_membus_addr))]++;
      $display("[ERROR] o_membus_data at %h expected %h got %h", $sampled(o_membus_addr),
               exp_data[$sampled(o_membus_addr[7:2])], $sampled(o_membus_data));
    end

  a_no_marker: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_membus_req && o_membus_write && i_membus_ack |-> o_membus_addr != MARKER)
    else begin
      errs[4]++;
      $display("a store reached the marker address %h, so a skip was not taken", MARKER);
    end

  a_iaddr_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_instbus_req |-> o_instbus_addr == held_iaddr)
    else begin
      errs[6]++;
      $display("[ERROR] o_instbus_addr expected %h got %h", held_iaddr, $sampled(o_instbus_addr));
    end

  a_maddr_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_membus_req |-> o_membus_addr == held_maddr)
    else begin
      errs[6]++;
      $display("[ERROR] o_membus_addr expected %h got %h", held_maddr, $sampled(o_membus_addr));
    end

  a_mwrite_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_membus_req |-> o_membus_write == held_mwrite)
    else begin
      errs[6]++;
      $display("[ERROR] o_membus_write expected %h got %h", held_mwrite,
               $sampled(o_membus_write));
    end

  a_mdata_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_membus_req |-> o_membus_data == held_mdata)
    else begin
      errs[6]++;
      $display("[ERROR] o_membus_data expected %h got %h", held_mdata, $sampled(o_membus_data));
    end

  initial begin
    int total_checks;
    int total_errs;
    void'($urandom(55));
    clk            = 1'b0;
    i_rst_n        = 1'b1;
    i_instbus_ack  = 1'b0;
    i_instbus_data = '0;
    i_membus_ack   = 1'b0;
    i_membus_data  = '0;
    ibusy          = 1'b0;
    mbusy          = 1'b0;
    iwait          = 0;
    mwait          = 0;
    held_iaddr     = '0;
    held_maddr     = '0;
    held_mwrite    = 1'b0;
    held_mdata     = '0;
    rst_q          = 1'b1;
    fetch_idx      = 0;
    cycles         = 0;
    n_inst         = 0;
    n_pc           = 0;
    total_checks   = 0;
    total_errs     = 0;
    for (int i = 1; i <= 6; i++) begin
      checks[i] = 0;
      errs[i]   = 0;
    end
    test_name[1] = "reset and first fetch";
    test_name[2] = "alu results";
    test_name[3] = "x0 writes";
    test_name[4] = "branch and jump";
    test_name[5] = "load word";
    test_name[6] = "bus stability";
    load_program();

    #5 i_rst_n = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    i_rst_n = 1'b1;

    while (fetch_idx < 1) @(negedge clk);
    report_test(1);
    // halt loop fetched
    while (fetch_idx < n_pc) @(negedge clk);
    repeat (2) @(negedge clk);
    check_all_stores();
    for (int i = 2; i <= 6; i++) begin
      report_test(i);
    end
    for (int i = 1; i <= 6; i++) begin
      total_checks += checks[i];
      total_errs   += errs[i];
    end
    $display("%0d checks, %0d passed, %0d failed", total_checks, total_checks - total_errs,
             total_errs);
    if (total_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+rtl
rtl/riscv_pkg.sv
rtl/riscv_ifu.sv
rtl/riscv_idu.sv
rtl/riscv_regfile.sv
rtl/riscv_exu.sv
rtl/riscv_lsu.sv
rtl/riscv.sv
bench/riscv_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= riscv_tb
RTL_TOP   ?= riscv
FILELIST  ?= filelist.f
OBJDIR    ?= obj_dir
PASS_MSG  := STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
